// ==== common/stream_pkg.sv ====
package stream_pkg;

    // Flit and buffer sizes
    localparam int FLIT_W    = 8;
    localparam int BUF_DEPTH = 8;
    localparam int CNT_W     = 4;   // Holds 0 to BUF_DEPTH

    // Programmable flag levels, compared against occupancy
    localparam int PROG_FULL_LVL  = 6;
    localparam int PROG_EMPTY_LVL = 2;

    // Downstream credit limit
    localparam int MAX_DN_CREDITS = 4;
    localparam int CREDIT_W       = 3;

    typedef logic [CNT_W-1:0]             count_t;
    typedef logic [CREDIT_W-1:0]          credit_t;
    typedef logic [$clog2(BUF_DEPTH)-1:0] ptr_t;

    typedef struct packed {
        logic [FLIT_W-1:0] data;
        logic              last;     // End of packet
    } flit_t;

    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
        logic prog_empty;
        logic overflow;              // Write rejected this cycle
        logic underflow;             // Read rejected this cycle
    } fifo_status_t;

endpackage

// ==== fifo/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter bit FWFT = 1'b0
) (
    input  logic                     i_Clk,
    input  logic                     i_rst_n,

    input  logic                     i_wr_en,
    input  stream_pkg::flit_t        i_wr_flit,

    input  logic                     i_rd_en,
    output stream_pkg::flit_t        o_rd_flit,

    output stream_pkg::fifo_status_t o_status,
    output stream_pkg::count_t       o_count
);

    stream_pkg::flit_t  mem [stream_pkg::BUF_DEPTH];

    stream_pkg::ptr_t   wr_ptr;
    stream_pkg::ptr_t   rd_ptr;
    stream_pkg::count_t count;

    logic full;
    logic empty;
    logic wr_ok;
    logic rd_ok;

    assign full  = (count == stream_pkg::count_t'(stream_pkg::BUF_DEPTH));
    assign empty = (count == '0);

    // A write into a full FIFO is refused even when a read frees a slot
    assign wr_ok = i_wr_en && !full;
    assign rd_ok = i_rd_en && !empty;

    always_ff @(posedge i_Clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wr_flit;
        end
    end

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;     // Depth is a power of two, wraps
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;   // Write, or read refused
                2'b01:   count <= count - 1'b1;   // Read, or write refused
                default: count <= count;          // Both or neither
            endcase
        end
    end

    generate
        if (FWFT) begin : g_fwft
            // Head of queue always on the output
            assign o_rd_flit = mem[rd_ptr];
        end else begin : g_reg_read
            stream_pkg::flit_t rd_q;

            always_ff @(posedge i_Clk) begin
                if (rd_ok) begin
                    rd_q <= mem[rd_ptr];
                end
            end

            assign o_rd_flit = rd_q;    // Valid the cycle after i_rd_en
        end
    endgenerate

    assign o_status.full       = full;
    assign o_status.empty      = empty;
    assign o_status.prog_full  = (count >= stream_pkg::count_t'(stream_pkg::PROG_FULL_LVL));
    assign o_status.prog_empty = (count <= stream_pkg::count_t'(stream_pkg::PROG_EMPTY_LVL));
    assign o_status.overflow   = i_wr_en && full;
    assign o_status.underflow  = i_rd_en && empty;

    assign o_count = count;

endmodule

// ==== source/credit_ingress.sv ====
`timescale 1ns/1ps

module credit_ingress (
    input  logic              i_Clk,
    input  logic              i_rst_n,

    input  logic              i_up_valid,
    input  stream_pkg::flit_t i_up_flit,

    input  logic              i_full,
    input  logic              i_pop,        // FIFO read enable from egress

    output logic              o_wr_en,
    output stream_pkg::flit_t o_wr_flit,

    output logic              o_up_credit,
    output logic              o_err_overflow
);

    stream_pkg::count_t init_cnt;   // Initial credits still to grant
    stream_pkg::count_t pend_cnt;   // Pops not yet returned as credit

    logic credit_q;
    logic err_q;

    // Flit goes straight to the FIFO, dropped when full
    assign o_wr_en   = i_up_valid && !i_full;
    assign o_wr_flit = i_up_flit;

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            init_cnt <= stream_pkg::count_t'(stream_pkg::BUF_DEPTH);
            pend_cnt <= '0;
            credit_q <= 1'b0;
        end else begin
            if (init_cnt != '0) begin
                // Initial grant has priority, pop waits in pending
                credit_q <= 1'b1;
                init_cnt <= init_cnt - 1'b1;
                if (i_pop) begin
                    pend_cnt <= pend_cnt + 1'b1;
                end
            end else if (i_pop || pend_cnt != '0) begin
                credit_q <= 1'b1;
                if (!i_pop) begin
                    pend_cnt <= pend_cnt - 1'b1;   // Drain one deferred return
                end
            end else begin
                credit_q <= 1'b0;
            end
        end
    end

    // Sticky until reset
    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else if (i_up_valid && i_full) begin
            err_q <= 1'b1;
        end
    end

    assign o_up_credit    = credit_q;
    assign o_err_overflow = err_q;

endmodule

// ==== source/credit_egress.sv ====
`timescale 1ns/1ps

module credit_egress (
    input  logic              i_Clk,
    input  logic              i_rst_n,

    input  logic              i_dn_credit,

    input  logic              i_empty,
    input  stream_pkg::flit_t i_rd_flit,    // Registered FIFO read data
    output logic              o_rd_en,

    output logic              o_dn_valid,
    output stream_pkg::flit_t o_dn_flit,

    output logic              o_err_credit
);

    stream_pkg::credit_t credits;

    logic pop;
    logic at_max;
    logic excess;
    logic take;
    logic valid_q;
    logic err_q;

    assign pop = (credits != '0) && !i_empty;

    // A pop in the same cycle makes room for the incoming credit
    assign at_max = (credits == stream_pkg::credit_t'(stream_pkg::MAX_DN_CREDITS));
    assign excess = i_dn_credit && at_max && !pop;
    assign take   = i_dn_credit && !excess;

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits <= '0;
        end else begin
            case ({take, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;       // Credit in and pop cancel
            endcase
        end
    end

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            valid_q <= pop;            // Lines up with the FIFO read data
            if (excess) begin
                err_q <= 1'b1;         // Excess credit is ignored
            end
        end
    end

    assign o_rd_en      = pop;
    assign o_dn_valid   = valid_q;
    assign o_dn_flit    = i_rd_flit;
    assign o_err_credit = err_q;

endmodule

// ==== source/stream_buffer.sv ====
`timescale 1ns/1ps

module stream_buffer (
    input  logic                     i_Clk,
    input  logic                     i_rst_n,

    // Upstream sender
    input  logic                     i_up_valid,
    input  stream_pkg::flit_t        i_up_flit,
    output logic                     o_up_credit,

    // Downstream receiver
    input  logic                     i_dn_credit,
    output logic                     o_dn_valid,
    output stream_pkg::flit_t        o_dn_flit,

    output stream_pkg::fifo_status_t o_fifo_status,
    output logic                     o_err_overflow,
    output logic                     o_err_credit
);

    logic                     wr_en;
    stream_pkg::flit_t        wr_flit;
    logic                     rd_en;      // Also the pop strobe to ingress
    stream_pkg::flit_t        rd_flit;
    stream_pkg::fifo_status_t fifo_status;

    credit_ingress u_ingress (
        .i_Clk          (i_Clk),
        .i_rst_n        (i_rst_n),
        .i_up_valid     (i_up_valid),
        .i_up_flit      (i_up_flit),
        .i_full         (fifo_status.full),
        .i_pop          (rd_en),
        .o_wr_en        (wr_en),
        .o_wr_flit      (wr_flit),
        .o_up_credit    (o_up_credit),
        .o_err_overflow (o_err_overflow)
    );

    sync_fifo #(
        .FWFT (1'b0)
    ) u_fifo (
        .i_Clk     (i_Clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (wr_en),
        .i_wr_flit (wr_flit),
        .i_rd_en   (rd_en),
        .o_rd_flit (rd_flit),
        .o_status  (fifo_status),
        .o_count   ()
    );

    credit_egress u_egress (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_dn_credit  (i_dn_credit),
        .i_empty      (fifo_status.empty),
        .i_rd_flit    (rd_flit),
        .o_rd_en      (rd_en),
        .o_dn_valid   (o_dn_valid),
        .o_dn_flit    (o_dn_flit),
        .o_err_credit (o_err_credit)
    );

    assign o_fifo_status = fifo_status;

endmodule

// ==== verif/stream_buffer_properties.sv ====
`timescale 1ns/1ps

module stream_buffer_properties (
    input logic                     i_Clk,
    input logic                     i_rst_n,
    input logic                     i_dn_credit,
    input logic                     o_up_credit,
    input logic                     o_dn_valid,
    input logic                     o_err_overflow,
    input logic                     o_err_credit
);

    int credit_total;
    int valid_total;
    int fail_count = 0;     // Failed assertions so far

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credit_total <= 0;
            valid_total  <= 0;
        end else begin
            credit_total <= credit_total + int'(i_dn_credit);
            valid_total  <= valid_total + int'(o_dn_valid);
        end
    end

    a_reset_quiet: assert property (@(posedge i_Clk)
        !i_rst_n |=> !o_up_credit && !o_dn_valid && !o_err_overflow && !o_err_credit)
        else begin
            fail_count++;
            $error("outputs not low after reset");
        end

    // Initial grant, one pulse per slot with nothing sent downstream
    a_init_grant: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        $rose(i_rst_n) |=> (o_up_credit && !o_dn_valid)[*stream_pkg::BUF_DEPTH])
        else begin
            fail_count++;
            $error("initial credit grant broken");
        end

    a_dn_discipline: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        o_dn_valid |-> valid_total < credit_total)
        else begin
            fail_count++;
            $error("flit sent downstream without a credit");
        end

    a_ovf_sticky: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        o_err_overflow |=> o_err_overflow)
        else begin
            fail_count++;
            $error("overflow error cleared without reset");
        end

    a_cerr_sticky: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
        o_err_credit |=> o_err_credit)
        else begin
            fail_count++;
            $error("credit error cleared without reset");
        end

endmodule

// ==== verif/tb_stream_buffer.sv ====
`timescale 1ns/1ps

module tb_stream_buffer;

    localparam int INIT_CYC  = 16;
    localparam int RAND_CYC  = 400;
    localparam int FILL_CYC  = 40;
    localparam int DRAIN_CYC = 80;
    localparam int TAIL_CYC  = 300;
    localparam int TIMEOUT   = 4 * (INIT_CYC + RAND_CYC + FILL_CYC + 2 * DRAIN_CYC + TAIL_CYC);

    logic                     i_Clk;
    logic                     i_rst_n;
    logic                     i_up_valid;
    logic                     i_dn_credit;
    stream_pkg::flit_t        i_up_flit;
    logic                     o_up_credit;
    logic                     o_dn_valid;
    logic                     o_err_overflow;
    logic                     o_err_credit;
    stream_pkg::flit_t        o_dn_flit;
    stream_pkg::fifo_status_t o_fifo_status;

    stream_pkg::flit_t exp_q[$];        // Scoreboard
    string test_name      = "reset";
    int    up_credits     = 0;          // Credits the sender holds
    int    dn_outstanding = 0;          // Returned, not yet used
    int    credits_seen   = 0;
    int    occ            = 0;          // Expected FIFO occupancy
    int    cycle_cnt      = 0;
    bit    wr_pend        = 1'b0;
    bit    ovf_exp        = 1'b0;
    bit    cerr_exp       = 1'b0;
    bit    cerr_exp_d     = 1'b0;

    stream_buffer i_dut (.*);

    bind stream_buffer stream_buffer_properties u_props (
        .i_Clk          (i_Clk),
        .i_rst_n        (i_rst_n),
        .i_dn_credit    (i_dn_credit),
        .o_up_credit    (o_up_credit),
        .o_dn_valid     (o_dn_valid),
        .o_err_overflow (o_err_overflow),
        .o_err_credit   (o_err_credit)
    );

    initial begin
        i_Clk = 1'b0;
        forever #2 i_Clk = ~i_Clk;
    end

    task automatic abort_run(string why);
        $display("ERROR: %s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string what, int expected, int actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED test=%s %s expected=0x%0h actual=0x%0h",
                     test_name, what, expected, actual);
            abort_run("wrong value");
        end
    endtask

    task automatic traffic_cycle(int send_pct, int credit_pct);
        stream_pkg::flit_t f;
        @(posedge i_Clk);
        #0.5;
        i_up_valid  = 1'b0;
        i_dn_credit = 1'b0;
        if (up_credits > 0 && $urandom_range(99) < send_pct) begin
            f.data     = 8'($urandom);
            f.last     = 1'($urandom_range(1));
            i_up_valid = 1'b1;
            i_up_flit  = f;
            exp_q.push_back(f);
            up_credits--;
        end
        if (dn_outstanding < stream_pkg::MAX_DN_CREDITS && $urandom_range(99) < credit_pct) begin
            i_dn_credit = 1'b1;
            dn_outstanding++;
        end
    endtask

    task automatic idle_cycles(int n);
        repeat (n) traffic_cycle(0, 0);
    endtask

    task automatic credit_pulse();
        @(posedge i_Clk);
        #0.5;
        i_dn_credit = 1'b1;
        if (dn_outstanding == stream_pkg::MAX_DN_CREDITS) begin
            cerr_exp = 1'b1;        // Egress already at its limit
        end else begin
            dn_outstanding++;
        end
    endtask

    initial begin
        void'($urandom(32'h857a_8f06));
        i_rst_n     = 1'b0;
        i_up_valid  = 1'b0;
        i_up_flit   = '0;
        i_dn_credit = 1'b0;
        repeat (8) @(posedge i_Clk);
        #0.5;
        i_rst_n = 1'b1;

        test_name = "initial credit grant";
        idle_cycles(INIT_CYC);
        check_value("credit pulses", stream_pkg::BUF_DEPTH, credits_seen);

        test_name = "order and integrity";
        repeat (RAND_CYC) traffic_cycle(70, 60);

        // Receiver goes quiet, sender spends every credit
        test_name = "fill";
        while (dn_outstanding != 0 || occ != stream_pkg::BUF_DEPTH) traffic_cycle(100, 0);
        idle_cycles(4);
        check_value("sender credits when full", 0, up_credits);

        test_name = "overflow";
        @(posedge i_Clk);
        #0.5;
        i_up_valid = 1'b1;                       // No credit held
        i_up_flit  = '{data: 8'ha5, last: 1'b1};
        idle_cycles(4);
        check_value("overflow error", 1, o_err_overflow);

        test_name = "drain";
        while (exp_q.size() != 0) traffic_cycle(0, 80);
        idle_cycles(4);

        test_name = "credit error";
        while (!cerr_exp) credit_pulse();
        idle_cycles(4);
        check_value("credit error", 1, o_err_credit);

        test_name = "traffic after errors";
        repeat (TAIL_CYC) traffic_cycle(60, 50);
        while (exp_q.size() != 0) traffic_cycle(0, 80);
        idle_cycles(4);

        if (i_dut.u_props.fail_count == 0 && exp_q.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "run stopped");
        end
    end

    // Mid-cycle sampling of DUT outputs
    always @(negedge i_Clk) begin
        if (i_rst_n) begin
            if (wr_pend) occ++;
            if (o_up_credit) begin
                up_credits++;
                credits_seen++;
            end
            if (o_dn_valid) begin
                occ--;                           // Pop and valid share an edge
                dn_outstanding--;
                assert (exp_q.size() != 0) else abort_run("flit came out with none expected");
                check_value("downstream flit", exp_q[0], o_dn_flit);
                void'(exp_q.pop_front());
            end
            check_value("full", occ == stream_pkg::BUF_DEPTH, o_fifo_status.full);
            check_value("empty", occ == 0, o_fifo_status.empty);
            check_value("prog_full", occ >= stream_pkg::PROG_FULL_LVL, o_fifo_status.prog_full);
            check_value("prog_empty", occ <= stream_pkg::PROG_EMPTY_LVL, o_fifo_status.prog_empty);
            // Ingress never writes a full FIFO, egress never reads an empty one
            check_value("fifo overflow", 0, o_fifo_status.overflow);
            check_value("fifo underflow", 0, o_fifo_status.underflow);
            check_value("overflow error", ovf_exp, o_err_overflow);
            check_value("credit error", cerr_exp_d, o_err_credit);
            // Inputs seen now act at the next edge
            ovf_exp    = ovf_exp || (i_up_valid && occ == stream_pkg::BUF_DEPTH);
            wr_pend    = i_up_valid && occ != stream_pkg::BUF_DEPTH;
            cerr_exp_d = cerr_exp;
            assert (i_dut.u_props.fail_count == 0) else abort_run("a DUT port assertion failed");
        end
    end

    always @(posedge i_Clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            abort_run($sformatf("timeout after %0d cycles", TIMEOUT));
        end
    end

endmodule

// ==== sim.f ====
common/stream_pkg.sv
fifo/sync_fifo.sv
source/credit_ingress.sv
source/credit_egress.sv
source/stream_buffer.sv
verif/stream_buffer_properties.sv
verif/tb_stream_buffer.sv

// ==== Bender.yml ====
package:
  name: stream_buffer

sources:
  - common/stream_pkg.sv
  - fifo/sync_fifo.sv
  - source/credit_ingress.sv
  - source/credit_egress.sv
  - source/stream_buffer.sv
  - target: simulation
    files:
      - verif/stream_buffer_properties.sv
      - verif/tb_stream_buffer.sv
